// ==== src/isa_pkg.sv ====
package isa_pkg;

   typedef logic [31:0] instr_t;
   typedef logic [4:0]  reg_addr_t;

   // Major opcodes still decoded by the core
   typedef enum logic [6:0] {
      OPC_OP     = 7'b0110011,
      OPC_OP_IMM = 7'b0010011,
      OPC_LUI    = 7'b0110111,
      OPC_STORE  = 7'b0100011
   } opcode_e;

   localparam logic [2:0] F3_ADD = 3'b000;
   localparam logic [2:0] F3_XOR = 3'b100;
   localparam logic [2:0] F3_OR  = 3'b110;
   localparam logic [2:0] F3_AND = 3'b111;

   typedef enum logic [1:0] {
      ALU_ADD = 2'd0,
      ALU_XOR = 2'd1,
      ALU_OR  = 2'd2,
      ALU_AND = 2'd3
   } alu_op_e;

   typedef struct packed {
      alu_op_e   alu_op;
      logic      sub;
      logic      use_imm;
      logic      pass_imm;
      logic      rd_we;
      logic      is_store;
      reg_addr_t rd;
   } ctrl_t;

endpackage

// ==== src/core_pkg.sv ====
package core_pkg;

   import isa_pkg::*;

   localparam int XLEN = 32;

   typedef logic [XLEN-1:0] word_t;
   typedef logic [4:0]      bit_idx_t;

   localparam word_t RESET_PC = 32'h0000_0000;

   typedef enum logic [2:0] {
      FETCH_REQ = 3'd0,
      FETCH_REL = 3'd1,
      EXEC      = 3'd2,
      STORE_REQ = 3'd3,
      STORE_REL = 3'd4
   } seq_state_e;

   typedef struct packed {
      logic  req;
      word_t adr;
   } ibus_req_t;

   typedef struct packed {
      logic   ack;
      instr_t rdt;
   } ibus_rsp_t;

   typedef struct packed {
      logic  req;
      word_t adr;
      word_t dat;
   } dbus_req_t;

endpackage

// ==== src/bit_counter.sv ====
`timescale 1ns/10ps

module bit_counter
   import core_pkg::*;
(
   input  logic     i_clk,
   input  logic     i_rst,
   input  logic     i_cnt_en,
   output bit_idx_t o_cnt,
   output logic     o_cnt_first,
   output logic     o_cnt_done
);

   bit_idx_t cnt;

   // Wraps from 31 back to 0 at the end of each instruction
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         cnt <= '0;
      end else if (i_cnt_en) begin
         cnt <= cnt + bit_idx_t'(1);
      end
   end

   assign o_cnt       = cnt;
   assign o_cnt_first = (cnt == '0);
   assign o_cnt_done  = &cnt;

endmodule

// ==== src/core_sequencer.sv ====
`timescale 1ns/10ps

module core_sequencer
   import core_pkg::*;
(
   input  logic  i_clk,
   input  logic  i_rst,
   input  logic  i_ibus_ack,
   input  logic  i_dbus_ack,
   input  logic  i_cnt_done,
   input  logic  i_is_store,
   output logic  o_ibus_req,
   output word_t o_ibus_adr,
   output logic  o_dbus_req,
   output logic  o_cnt_en,
   output logic  o_instr_load,
   output logic  o_exec
);

   seq_state_e state;
   word_t      pc;
   logic       ibus_req;
   logic       dbus_req;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state    <= FETCH_REQ;
         pc       <= RESET_PC;
         ibus_req <= 1'b0;
         dbus_req <= 1'b0;
      end else begin
         case (state)
            FETCH_REQ: begin
               if (ibus_req && i_ibus_ack) begin
                  ibus_req <= 1'b0;
                  state    <= FETCH_REL;
               end else begin
                  ibus_req <= 1'b1;
               end
            end
            FETCH_REL: begin
               if (!i_ibus_ack) begin
                  state <= EXEC;
               end
            end
            EXEC: begin
               if (i_cnt_done) begin
                  pc <= pc + word_t'(4);
                  if (i_is_store) begin
                     dbus_req <= 1'b1;
                     state    <= STORE_REQ;
                  end else begin
                     ibus_req <= 1'b1;
                     state    <= FETCH_REQ;
                  end
               end
            end
            STORE_REQ: begin
               if (i_dbus_ack) begin
                  dbus_req <= 1'b0;
                  state    <= STORE_REL;
               end
            end
            STORE_REL: begin
               // Back to fetch once the data bus ack drops
               if (!i_dbus_ack) begin
                  ibus_req <= 1'b1;
                  state    <= FETCH_REQ;
               end
            end
            default: state <= FETCH_REQ;
         endcase
      end
   end

   assign o_ibus_req   = ibus_req;
   assign o_ibus_adr   = pc;
   assign o_dbus_req   = dbus_req;
   assign o_exec       = (state == EXEC);
   assign o_cnt_en     = (state == EXEC);
   assign o_instr_load = (state == FETCH_REQ) & ibus_req & i_ibus_ack;

endmodule

// ==== src/instr_decoder.sv ====
`timescale 1ns/10ps

module instr_decoder
   import core_pkg::*;
   import isa_pkg::*;
(
   input  logic      i_clk,
   input  logic      i_rst,
   input  logic      i_instr_load,
   input  instr_t    i_rdt,
   input  bit_idx_t  i_cnt,
   output ctrl_t     o_ctrl,
   output reg_addr_t o_rs1_addr,
   output reg_addr_t o_rs2_addr,
   output logic      o_imm_bit
);

   instr_t     instr;
   logic [2:0] funct3;
   word_t      imm;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         instr <= '0;
      end else if (i_instr_load) begin
         instr <= i_rdt;
      end
   end

   assign funct3 = instr[14:12];

   always_comb begin
      o_ctrl          = '0;
      o_ctrl.rd       = instr[11:7];
      case (funct3)
         F3_XOR:  o_ctrl.alu_op = ALU_XOR;
         F3_OR:   o_ctrl.alu_op = ALU_OR;
         F3_AND:  o_ctrl.alu_op = ALU_AND;
         default: o_ctrl.alu_op = ALU_ADD;
      endcase
      // SLT and shift encodings fall through as no-ops
      case (instr[6:0])
         OPC_OP: begin
            o_ctrl.rd_we = (funct3 == F3_ADD) || (funct3 == F3_XOR) ||
                           (funct3 == F3_OR)  || (funct3 == F3_AND);
            o_ctrl.sub   = (funct3 == F3_ADD) & instr[30];
         end
         OPC_OP_IMM: begin
            o_ctrl.use_imm = 1'b1;
            o_ctrl.rd_we   = (funct3 == F3_ADD) || (funct3 == F3_XOR) ||
                             (funct3 == F3_OR)  || (funct3 == F3_AND);
         end
         OPC_LUI: begin
            o_ctrl.pass_imm = 1'b1;
            o_ctrl.rd_we    = 1'b1;
         end
         OPC_STORE: begin
            o_ctrl.alu_op   = ALU_ADD;
            o_ctrl.use_imm  = 1'b1;
            o_ctrl.is_store = 1'b1;
         end
         default: o_ctrl.rd_we = 1'b0;
      endcase
   end

   // I-type unless store or LUI
   always_comb begin
      case (instr[6:0])
         OPC_STORE: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
         OPC_LUI:   imm = {instr[31:12], 12'h000};
         default:   imm = {{20{instr[31]}}, instr[31:20]};
      endcase
   end

   assign o_imm_bit  = imm[i_cnt];
   assign o_rs1_addr = instr[19:15];
   assign o_rs2_addr = instr[24:20];

endmodule

// ==== src/serial_regfile.sv ====
`timescale 1ns/10ps

module serial_regfile
   import core_pkg::*;
   import isa_pkg::*;
(
   input  logic      i_clk,
   input  logic      i_we,
   input  reg_addr_t i_rd_addr,
   input  reg_addr_t i_rs1_addr,
   input  reg_addr_t i_rs2_addr,
   input  bit_idx_t  i_cnt,
   input  logic      i_rd_bit,
   output logic      o_rs1_bit,
   output logic      o_rs2_bit
);

   // One bit per entry, indexed by {register, bit position}
   logic mem [0:32*XLEN-1];

   always_ff @(posedge i_clk) begin
      if (i_we && (i_rd_addr != '0)) begin
         mem[{i_rd_addr, i_cnt}] <= i_rd_bit;
      end
   end

   // x0 is never written, so its reads are forced low
   assign o_rs1_bit = (i_rs1_addr != '0) & mem[{i_rs1_addr, i_cnt}];
   assign o_rs2_bit = (i_rs2_addr != '0) & mem[{i_rs2_addr, i_cnt}];

endmodule

// ==== src/serial_alu.sv ====
`timescale 1ns/10ps

module serial_alu
   import isa_pkg::*;
(
   input  logic  i_clk,
   input  logic  i_rst,
   input  logic  i_en,
   input  logic  i_first,
   input  ctrl_t i_ctrl,
   input  logic  i_rs1_bit,
   input  logic  i_rs2_bit,
   input  logic  i_imm_bit,
   output logic  o_rd_bit
);

   logic op_b;
   logic add_b;
   logic carry_in;
   logic carry;
   logic sum;

   assign op_b     = i_ctrl.use_imm ? i_imm_bit : i_rs2_bit;
   // Subtract as rs1 + ~rs2 + 1
   assign add_b    = op_b ^ i_ctrl.sub;
   assign carry_in = i_first ? i_ctrl.sub : carry;
   assign sum      = i_rs1_bit ^ add_b ^ carry_in;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         carry <= 1'b0;
      end else if (i_en) begin
         carry <= (i_rs1_bit & add_b) | (i_rs1_bit & carry_in) | (add_b & carry_in);
      end
   end

   always_comb begin
      if (i_ctrl.pass_imm) begin
         o_rd_bit = i_imm_bit;
      end else begin
         case (i_ctrl.alu_op)
            ALU_XOR: o_rd_bit = i_rs1_bit ^ op_b;
            ALU_OR:  o_rd_bit = i_rs1_bit | op_b;
            ALU_AND: o_rd_bit = i_rs1_bit & op_b;
            default: o_rd_bit = sum;
         endcase
      end
   end

endmodule

// ==== src/store_buffer.sv ====
`timescale 1ns/10ps

module store_buffer
   import core_pkg::*;
(
   input  logic  i_clk,
   input  logic  i_rst,
   input  logic  i_shift,
   input  logic  i_adr_bit,
   input  logic  i_dat_bit,
   output word_t o_adr,
   output word_t o_dat
);

   word_t adr;
   word_t dat;

   // LSB enters first and ends up in bit 0 after 32 shifts
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         adr <= '0;
         dat <= '0;
      end else if (i_shift) begin
         adr <= {i_adr_bit, adr[XLEN-1:1]};
         dat <= {i_dat_bit, dat[XLEN-1:1]};
      end
   end

   assign o_adr = adr;
   assign o_dat = dat;

endmodule

// ==== src/serial_core.sv ====
`timescale 1ns/10ps

module serial_core
   import core_pkg::*;
   import isa_pkg::*;
(
   input  logic      i_clk,
   input  logic      i_rst,
   output ibus_req_t o_ibus,
   input  ibus_rsp_t i_ibus,
   output dbus_req_t o_dbus,
   input  logic      i_dbus_ack
);

   word_t     ibus_adr;
   logic      ibus_req;
   logic      dbus_req;
   logic      cnt_en;
   logic      instr_load;
   logic      exec;
   bit_idx_t  cnt;
   logic      cnt_first;
   logic      cnt_done;
   ctrl_t     ctrl;
   reg_addr_t rs1_addr;
   reg_addr_t rs2_addr;
   logic      imm_bit;
   logic      rs1_bit;
   logic      rs2_bit;
   logic      rd_bit;
   word_t     st_adr;
   word_t     st_dat;

   assign o_ibus.req = ibus_req;
   assign o_ibus.adr = ibus_adr;
   assign o_dbus.req = dbus_req;
   assign o_dbus.adr = st_adr;
   assign o_dbus.dat = st_dat;

   core_sequencer u_sequencer (
      .i_clk        (i_clk          ),
      .i_rst        (i_rst          ),
      .i_ibus_ack   (i_ibus.ack     ),
      .i_dbus_ack   (i_dbus_ack     ),
      .i_cnt_done   (cnt_done       ),
      .i_is_store   (ctrl.is_store  ),
      .o_ibus_req   (ibus_req       ),
      .o_ibus_adr   (ibus_adr       ),
      .o_dbus_req   (dbus_req       ),
      .o_cnt_en     (cnt_en         ),
      .o_instr_load (instr_load     ),
      .o_exec       (exec           )
   );

   bit_counter u_counter (
      .i_clk       (i_clk     ),
      .i_rst       (i_rst     ),
      .i_cnt_en    (cnt_en    ),
      .o_cnt       (cnt       ),
      .o_cnt_first (cnt_first ),
      .o_cnt_done  (cnt_done  )
   );

   instr_decoder u_decoder (
      .i_clk        (i_clk       ),
      .i_rst        (i_rst       ),
      .i_instr_load (instr_load  ),
      .i_rdt        (i_ibus.rdt  ),
      .i_cnt        (cnt         ),
      .o_ctrl       (ctrl        ),
      .o_rs1_addr   (rs1_addr    ),
      .o_rs2_addr   (rs2_addr    ),
      .o_imm_bit    (imm_bit     )
   );

   // Result goes back to rd only for register-writing ops
   serial_regfile u_regfile (
      .i_clk      (i_clk               ),
      .i_we       (exec & ctrl.rd_we   ),
      .i_rd_addr  (ctrl.rd             ),
      .i_rs1_addr (rs1_addr            ),
      .i_rs2_addr (rs2_addr            ),
      .i_cnt      (cnt                 ),
      .i_rd_bit   (rd_bit              ),
      .o_rs1_bit  (rs1_bit             ),
      .o_rs2_bit  (rs2_bit             )
   );

   serial_alu u_alu (
      .i_clk     (i_clk     ),
      .i_rst     (i_rst     ),
      .i_en      (exec      ),
      .i_first   (cnt_first ),
      .i_ctrl    (ctrl      ),
      .i_rs1_bit (rs1_bit   ),
      .i_rs2_bit (rs2_bit   ),
      .i_imm_bit (imm_bit   ),
      .o_rd_bit  (rd_bit    )
   );

   // ALU result is the store address, rs2 the store data
   store_buffer u_store_buffer (
      .i_clk     (i_clk                 ),
      .i_rst     (i_rst                 ),
      .i_shift   (exec & ctrl.is_store  ),
      .i_adr_bit (rd_bit                ),
      .i_dat_bit (rs2_bit               ),
      .o_adr     (st_adr                ),
      .o_dat     (st_dat                )
   );

endmodule

// ==== verif/serial_core_chk.sv ====
`timescale 1ns/10ps

module serial_core_chk
   import core_pkg::*;
(
   input logic      i_clk,
   input logic      i_rst,
   input ibus_req_t i_ibus_req,
   input logic      i_ibus_ack,
   input dbus_req_t i_dbus_req,
   input logic      i_dbus_ack
);

   // Requests hold until the responder acks
   ibus_req_hold: assert property (@(posedge i_clk) disable iff (i_rst)
      i_ibus_req.req && !i_ibus_ack |=> i_ibus_req.req)
      else $error("ibus req dropped before ack");

   dbus_req_hold: assert property (@(posedge i_clk) disable iff (i_rst)
      i_dbus_req.req && !i_dbus_ack |=> i_dbus_req.req)
      else $error("dbus req dropped before ack");

   ibus_adr_stable: assert property (@(posedge i_clk) disable iff (i_rst)
      i_ibus_req.req && !i_ibus_ack |=> $stable(i_ibus_req.adr))
      else $error("ibus address changed under req");

   dbus_payload_stable: assert property (@(posedge i_clk) disable iff (i_rst)
      i_dbus_req.req && !i_dbus_ack |=> $stable(i_dbus_req.adr) && $stable(i_dbus_req.dat))
      else $error("dbus address or data changed under req");

   // One instruction in flight, so never both buses at once
   req_exclusive: assert property (@(posedge i_clk) disable iff (i_rst)
      !(i_ibus_req.req && i_dbus_req.req))
      else $error("ibus and dbus req high together");

endmodule

bind serial_core serial_core_chk i_chk (
   .i_clk      (i_clk      ),
   .i_rst      (i_rst      ),
   .i_ibus_req (o_ibus     ),
   .i_ibus_ack (i_ibus.ack ),
   .i_dbus_req (o_dbus     ),
   .i_dbus_ack (i_dbus_ack )
);

// ==== verif/tb_serial_core.sv ====
`timescale 1ns/10ps

module tb_serial_core
   import core_pkg::*;
   import isa_pkg::*;
();

   localparam int         MEM_WORDS    = 512;
   localparam int         WAIT_TIMEOUT = 200;
   localparam int         RUN_TIMEOUT  = 4000;
   localparam logic [8:0] STORE_BASE   = 9'h100;
   localparam logic [31:0] LCG_SEED    = 32'hc724_9278;

   logic      clk = 1'b0;
   logic      rst;
   ibus_req_t ibus_req;
   ibus_rsp_t ibus_rsp;
   dbus_req_t dbus_req;
   logic      dbus_ack;

   // Program image below STORE_BASE, expected stores from STORE_BASE up
   word_t       tests_mem [0:MEM_WORDS-1];
   logic [31:0] lcg_state;
   int          n_stores;
   int          stores_seen;

   always #10 clk = ~clk;

   serial_core i_serial_core (
      .i_clk      (clk      ),
      .i_rst      (rst      ),
      .o_ibus     (ibus_req ),
      .i_ibus     (ibus_rsp ),
      .o_dbus     (dbus_req ),
      .i_dbus_ack (dbus_ack )
   );

   task automatic report_error(input string msg);
      $display("Error at %0t ns: %s", $time, msg);
      $display("Simulation FAILED");
      $fatal(1, "stopping on first error");
   endtask

   task automatic check_word(input word_t got, input word_t exp, input string what);
      if (got !== exp) begin
         $display("Mismatch at %0t ns: %s expected %h, got %h", $time, what, exp, got);
         report_error({what, " mismatch"});
      end
   endtask

   task automatic check_store(input dbus_req_t got, input dbus_req_t exp, input string what);
      if (got !== exp) begin
         $display("Mismatch at %0t ns: %s expected adr %h dat %h, got adr %h dat %h",
                  $time, what, exp.adr, exp.dat, got.adr, got.dat);
         report_error({what, " mismatch"});
      end
   endtask

   // Numerical Recipes constants give an ack delay of 0 to 3 cycles
   function automatic int next_delay();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return {30'b0, lcg_state[17:16]};
   endfunction

   function automatic instr_t fetch_word(input word_t adr);
      if (adr < 32'h400) begin
         return tests_mem[{1'b0, adr[9:2]}];
      end else begin
         return '0;
      end
   endfunction

   task automatic hold_cycles(input int n);
      repeat (n) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic wait_any_req();
      int cycles;
      cycles = 0;
      while ((ibus_req.req !== 1'b1) && (dbus_req.req !== 1'b1)) begin
         @(posedge clk);
         #1;
         cycles++;
         if (cycles > WAIT_TIMEOUT) begin
            report_error("timeout waiting for a fetch or store request");
         end
      end
   endtask

   task automatic wait_req_drop(input logic on_ibus, input string what);
      int cycles;
      cycles = 0;
      while ((on_ibus ? ibus_req.req : dbus_req.req) !== 1'b0) begin
         @(posedge clk);
         #1;
         cycles++;
         if (cycles > WAIT_TIMEOUT) begin
            report_error({"timeout waiting for the ", what, " request to drop"});
         end
      end
   endtask

   // Serves both buses since only one is ever active
   initial begin : bus_responder
      word_t      exp_fetch;
      dbus_req_t  exp_store;
      logic [8:0] st_ptr;
      ibus_rsp    = '0;
      dbus_ack    = 1'b0;
      lcg_state   = LCG_SEED;
      stores_seen = 0;
      exp_fetch   = RESET_PC;
      st_ptr      = STORE_BASE + 9'd1;
      forever begin
         wait_any_req();
         if (ibus_req.req === 1'b1) begin
            check_word(ibus_req.adr, exp_fetch, "fetch address");
            hold_cycles(next_delay());
            ibus_rsp.rdt = fetch_word(ibus_req.adr);
            ibus_rsp.ack = 1'b1;
            wait_req_drop(1'b1, "fetch");
            hold_cycles(next_delay());
            ibus_rsp.ack = 1'b0;
            exp_fetch = exp_fetch + word_t'(4);
         end else begin
            if (stores_seen >= n_stores) begin
               report_error("store seen after the last expected one");
            end
            exp_store.req = 1'b1;
            exp_store.adr = tests_mem[st_ptr];
            exp_store.dat = tests_mem[st_ptr + 9'd1];
            check_store(dbus_req, exp_store, "store");
            hold_cycles(next_delay());
            dbus_ack = 1'b1;
            wait_req_drop(1'b0, "store");
            hold_cycles(next_delay());
            dbus_ack = 1'b0;
            st_ptr = st_ptr + 9'd2;
            stores_seen++;
         end
      end
   end

   initial begin : main
      int cycles;
      rst = 1'b1;
      // Opcode field stays zero, so unused words decode as no-ops
      for (int i = 0; i < MEM_WORDS; i++) begin
         tests_mem[i[8:0]] = word_t'(i) << 7;
      end
      $readmemh("verif/serial_core_tests.txt", tests_mem);
      n_stores = int'(tests_mem[STORE_BASE]);
      if (n_stores == 0) begin
         report_error("the test file lists no expected stores");
      end
      repeat (8) begin
         @(posedge clk);
         #1;
         if ((ibus_req.req !== 1'b0) || (dbus_req.req !== 1'b0)) begin
            report_error("a bus request was raised during reset");
         end
      end
      rst = 1'b0;
      cycles = 0;
      while (stores_seen < n_stores) begin
         @(posedge clk);
         #1;
         cycles++;
         if (cycles > RUN_TIMEOUT) begin
            report_error("timeout before all expected stores were seen");
         end
      end
      $display("Simulation PASSED");
      $finish;
   end

endmodule

// ==== compile.f ====
src/isa_pkg.sv
src/core_pkg.sv
src/bit_counter.sv
src/core_sequencer.sv
src/instr_decoder.sv
src/serial_regfile.sv
src/serial_alu.sv
src/store_buffer.sv
src/serial_core.sv
verif/serial_core_chk.sv
verif/tb_serial_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_serial_core
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then echo "Run failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "Simulation PASSED" $(LOG); then echo "Run incomplete, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verif/serial_core_tests.txt ====
// Program words from address 0, one per line
// At 100: number of stores, then one store per line as address and data
@000
123450B7 // lui  x1, 0x12345
67800113 // addi x2, x0, 0x678
002081B3 // add  x3, x1, x2
10302023 // sw   x3, 0x100(x0)
00419193 // slli x3, x3, 4 (no-op here)
FFF00213 // addi x4, x0, -1
0F024293 // xori x5, x4, 0x0f0
10502223 // sw   x5, 0x104(x0)
7F01F313 // andi x6, x3, 0x7f0
80016393 // ori  x7, x2, -0x800
FE60AE23 // sw   x6, -4(x1)
00712423 // sw   x7, 8(x2)
40310433 // sub  x8, x2, x3
0051F4B3 // and  x9, x3, x5
00136533 // or   x10, x6, x1
0071C5B3 // xor  x11, x3, x7
00802823 // sw   x8, 0x10(x0)
00902A23 // sw   x9, 0x14(x0)
00A02C23 // sw   x10, 0x18(x0)
00B02E23 // sw   x11, 0x1c(x0)
05500013 // addi x0, x0, 0x55
02002023 // sw   x0, 0x20(x0)
00110113 // addi x2, x2, 1
02202223 // sw   x2, 0x24(x0)
@100
0000000A
00000100 12345678
00000104 FFFFFF0F
12344FFC 00000670
00000680 FFFFFE78
00000010 EDCBB000
00000014 12345608
00000018 12345670
0000001C EDCBA800
00000020 00000000
00000024 00000679
